/* testbench/keep_filter_testdata.txt */
# Columns of I and O lines are keep, data and last in hex (I input beat, O expected output beat)
# The C line holds the expected pkts_sent, beats_dropped and pkts_dropped in decimal
I f 11110001 0
I f 11110002 0
I f 11110003 1
O f 11110001 0
O f 11110002 0
O f 11110003 1
I f 22220001 0
I 0 22220002 0
I 3 22220003 0
I 0 22220004 0
I c 22220005 1
O f 22220001 0
O 3 22220003 0
O c 22220005 1
I 1 33330001 0
I 8 33330002 0
I 0 33330003 1
O 1 33330001 0
O 8 33330002 1
I 0 44440001 0
I 0 44440002 0
I 0 44440003 1
I 6 55550001 1
O 6 55550001 1
I 0 66660001 1
I 0 77770001 0
I 5 77770002 0
I 0 77770003 0
I 0 77770004 1
O 5 77770002 1
I f 88880001 0
I f 88880002 0
I f 88880003 0
I f 88880004 1
O f 88880001 0
O f 88880002 0
O f 88880003 0
O f 88880004 1
C 6 10 2

/* list.f */
+incdir+rtl
rtl/keep_filter_pkg.sv
rtl/sync_fifo.sv
rtl/beat_status_stage.sv
rtl/keep_filter_fifo.sv
rtl/filter_stats.sv
rtl/axis_keep_filter_top.sv
testbench/axis_keep_filter_checker.sv
testbench/axis_keep_filter_tb.sv

/* Makefile */
# Verilator build, run and lint for the stream keep filter

VERILATOR ?= verilator
TOP       ?= axis_keep_filter_tb
LINT_TOP  ?= axis_keep_filter_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/axis_keep_filter_tb.sv */
// Stream keep filter testbench
// File-driven stimulus with random input gaps and output stalls,
// a scoreboard on every output handshake and a final statistics check

`timescale 1ns/10ps
`default_nettype none

module axis_keep_filter_tb
    import keep_filter_pkg::*;
();

    localparam int BEAT_W = $bits(tdata_t) + $bits(tkeep_t) + 1;

    logic   axis_out;
    logic   reset_w_bytes;
    logic   in_tvalid;
    tdata_t in_tdata;
    tkeep_t in_tkeep;
    logic   in_tlast;
    logic   in_tready;
    logic   out_tvalid;
    tdata_t out_tdata;
    tkeep_t out_tkeep;
    logic   out_tlast;
    logic   out_tready;
    stat_t  pkts_sent;
    stat_t  beats_dropped;
    stat_t  pkts_dropped;

    // Beats packed as {last, keep, data}
    logic [BEAT_W-1:0] in_q[$];
    logic [BEAT_W-1:0] exp_q[$];
    stat_t             exp_sent;
    stat_t             exp_bdrop;
    stat_t             exp_pdrop;
    int                exp_idx;
    integer            seed;

    axis_keep_filter_top i_axis_keep_filter_top (
        .axis_out (axis_out), .reset_w_bytes (reset_w_bytes),
        .in_tvalid (in_tvalid), .in_tdata (in_tdata), .in_tkeep (in_tkeep),
        .in_tlast (in_tlast), .in_tready (in_tready),
        .out_tvalid (out_tvalid), .out_tdata (out_tdata), .out_tkeep (out_tkeep),
        .out_tlast (out_tlast), .out_tready (out_tready),
        .pkts_sent (pkts_sent), .beats_dropped (beats_dropped),
        .pkts_dropped (pkts_dropped)
    );

    bind axis_keep_filter_top axis_keep_filter_checker i_checker (
        .axis_out (axis_out), .reset_w_bytes (reset_w_bytes), .in_tready (in_tready),
        .out_tvalid (out_tvalid), .out_tdata (out_tdata), .out_tkeep (out_tkeep),
        .out_tlast (out_tlast), .out_tready (out_tready)
    );

    initial begin
        axis_out = 1'b0;
        forever #5 axis_out = ~axis_out;
    end

    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        fail_run();
    endtask

    task automatic read_testdata();
        integer             fd;
        integer             code;
        logic [7:0]         tag;
        logic [8*128-1:0]   rest;
        tkeep_t             f_keep;
        tdata_t             f_data;
        logic               f_last;
        logic               have_counts;
        have_counts = 1'b0;
        fd = $fopen("testbench/keep_filter_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file");
            fail_run();
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I" || tag == "O") begin
                code = $fscanf(fd, "%h %h %h", f_keep, f_data, f_last);
                if (code != 3) begin
                    $display("Malformed beat record in the test data file");
                    fail_run();
                end
                if (tag == "I") begin
                    in_q.push_back({f_last, f_keep, f_data});
                end else begin
                    exp_q.push_back({f_last, f_keep, f_data});
                end
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d %d %d", exp_sent, exp_bdrop, exp_pdrop);
                have_counts = (code == 3);
            end else begin
                $display("Unknown record kind in the test data file");
                fail_run();
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        if (!have_counts || in_q.size() == 0) begin
            $display("Test data file has no input beats or no count line");
            fail_run();
        end
    endtask

    task automatic check_beat();
        tdata_t e_data;
        tkeep_t e_keep;
        logic   e_last;
        assert (exp_idx < exp_q.size())
            else begin
                $display("Output beat at %0t with no expected beat left", $time);
                fail_run();
            end
        {e_last, e_keep, e_data} = exp_q[exp_idx];
        assert (out_tdata == e_data)
            else report_mismatch("out_tdata", e_data, out_tdata);
        assert (out_tkeep == e_keep)
            else report_mismatch("out_tkeep", 32'(e_keep), 32'(out_tkeep));
        assert (out_tlast == e_last)
            else report_mismatch("out_tlast", 32'(e_last), 32'(out_tlast));
        exp_idx++;
    endtask

    task automatic check_counts();
        assert (pkts_sent == exp_sent)
            else report_mismatch("pkts_sent", 32'(exp_sent), 32'(pkts_sent));
        assert (beats_dropped == exp_bdrop)
            else report_mismatch("beats_dropped", 32'(exp_bdrop), 32'(beats_dropped));
        assert (pkts_dropped == exp_pdrop)
            else report_mismatch("pkts_dropped", 32'(exp_pdrop), 32'(pkts_dropped));
        // Nothing left to send once every packet is out
        assert (!out_tvalid)
            else report_mismatch("out_tvalid", 32'd0, 32'(out_tvalid));
    endtask

    // Values sampled at the falling edge are those of the next rising edge
    always @(negedge axis_out) begin
        if (!reset_w_bytes && out_tvalid && out_tready) begin
            check_beat();
        end
    end

    // One draw per cycle sets both the input gap and the output stall
    initial begin : stimulus
        int          idx;
        logic        took;
        logic [31:0] rnd;
        idx = 0;
        @(negedge reset_w_bytes);
        forever begin
            @(negedge axis_out);
            took = in_tvalid && in_tready;
            @(posedge axis_out);
            #1;
            if (took) begin
                idx++;
            end
            rnd = $random(seed);
            out_tready = (rnd[1:0] != 2'b00);
            if (in_tvalid && !took) begin
                in_tvalid = 1'b1;
            end else if (idx < in_q.size() && rnd[3:2] != 2'b00) begin
                {in_tlast, in_tkeep, in_tdata} = in_q[idx];
                in_tvalid = 1'b1;
            end else begin
                in_tvalid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        @(negedge reset_w_bytes);
        repeat (40 * in_q.size() + 200) @(posedge axis_out);
        $display("Timeout with %0d of %0d expected beats received", exp_idx, exp_q.size());
        fail_run();
    end

    initial begin
        seed          = 32'hf486_f0fa;
        reset_w_bytes = 1'b1;
        in_tvalid     = 1'b0;
        in_tdata      = '0;
        in_tkeep      = '0;
        in_tlast      = 1'b0;
        out_tready    = 1'b0;
        exp_idx       = 0;
        read_testdata();
        repeat (2) @(posedge axis_out);
        #1;
        reset_w_bytes = 1'b0;
        while (exp_idx < exp_q.size()) begin
            @(negedge axis_out);
        end
        // Let the last handshake reach the counters, and catch extra beats
        repeat (4) @(negedge axis_out);
        check_counts();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/axis_keep_filter_checker.sv */
// Stream keep filter protocol checker
// Output hold rules under back-pressure and in_tready during reset

`timescale 1ns/10ps
`default_nettype none

module axis_keep_filter_checker
    import keep_filter_pkg::*;
(
    input logic   axis_out,
    input logic   reset_w_bytes,
    input logic   in_tready,
    input logic   out_tvalid,
    input tdata_t out_tdata,
    input tkeep_t out_tkeep,
    input logic   out_tlast,
    input logic   out_tready
);

    // Stalled beat stays offered
    out_valid_held_a: assert property (@(posedge axis_out) disable iff (reset_w_bytes)
        out_tvalid && !out_tready |=> out_tvalid)
        else $error("out_tvalid fell before its handshake");

    // Stalled beat keeps its payload
    out_data_stable_a: assert property (@(posedge axis_out) disable iff (reset_w_bytes)
        out_tvalid && !out_tready |=> $stable(out_tdata) && $stable(out_tkeep)
            && $stable(out_tlast))
        else $error("Output beat changed before its handshake");

    in_ready_reset_a: assert property (@(posedge axis_out)
        reset_w_bytes && $past(reset_w_bytes) |-> !in_tready)
        else $error("in_tready high while reset is active");

endmodule

`default_nettype wire

/* rtl/axis_keep_filter_top.sv */
// Stream keep filter top level
// Status stage, packet filter core and statistics counters

`timescale 1ns/10ps
`default_nettype none

module axis_keep_filter_top
    import keep_filter_pkg::*;
(
    input  logic   axis_out,
    input  logic   reset_w_bytes,
    input  logic   in_tvalid,
    input  tdata_t in_tdata,
    input  tkeep_t in_tkeep,
    input  logic   in_tlast,
    output logic   in_tready,
    output logic   out_tvalid,
    output tdata_t out_tdata,
    output tkeep_t out_tkeep,
    output logic   out_tlast,
    input  logic   out_tready,
    output stat_t  pkts_sent,
    output stat_t  beats_dropped,
    output stat_t  pkts_dropped
);

    logic   stg_tvalid;
    tdata_t stg_tdata;
    tkeep_t stg_tkeep;
    logic   stg_tlast;
    logic   stg_empty;
    logic   stg_ready;
    logic   beat_drop;
    logic   packet_drop;
    logic   pkt_sent;

    // One packet leaves per output last handshake
    assign pkt_sent = out_tvalid && out_tready && out_tlast;

    beat_status_stage i_beat_status_stage (
        .axis_out (axis_out), .reset_w_bytes (reset_w_bytes),
        .in_tvalid (in_tvalid), .in_tdata (in_tdata), .in_tkeep (in_tkeep),
        .in_tlast (in_tlast), .in_tready (in_tready),
        .stg_tvalid (stg_tvalid), .stg_tdata (stg_tdata), .stg_tkeep (stg_tkeep),
        .stg_tlast (stg_tlast), .stg_empty (stg_empty), .stg_ready (stg_ready)
    );

    keep_filter_fifo i_keep_filter_fifo (
        .axis_out (axis_out), .reset_w_bytes (reset_w_bytes),
        .stg_tvalid (stg_tvalid), .stg_tdata (stg_tdata), .stg_tkeep (stg_tkeep),
        .stg_tlast (stg_tlast), .stg_empty (stg_empty), .stg_ready (stg_ready),
        .out_tvalid (out_tvalid), .out_tdata (out_tdata), .out_tkeep (out_tkeep),
        .out_tlast (out_tlast), .out_tready (out_tready),
        .beat_drop (beat_drop), .packet_drop (packet_drop)
    );

    filter_stats i_filter_stats (
        .axis_out (axis_out), .reset_w_bytes (reset_w_bytes),
        .pkt_sent (pkt_sent), .beat_drop (beat_drop), .packet_drop (packet_drop),
        .pkts_sent (pkts_sent), .beats_dropped (beats_dropped),
        .pkts_dropped (pkts_dropped)
    );

endmodule

`default_nettype wire

/* rtl/filter_stats.sv */
// Filter statistics
// Saturating event counters for packets sent, beats dropped
// and packets dropped

`timescale 1ns/10ps
`default_nettype none

module filter_stats
    import keep_filter_pkg::*;
(
    input  logic  axis_out,
    input  logic  reset_w_bytes,
    input  logic  pkt_sent,
    input  logic  beat_drop,
    input  logic  packet_drop,
    output stat_t pkts_sent,
    output stat_t beats_dropped,
    output stat_t pkts_dropped
);

    // Stick at all ones instead of wrapping
    function automatic stat_t sat_inc(input stat_t value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

    always_ff @(posedge axis_out) begin
        if (reset_w_bytes) begin
            pkts_sent     <= '0;
            beats_dropped <= '0;
            pkts_dropped  <= '0;
        end else begin
            if (pkt_sent) begin
                pkts_sent <= sat_inc(pkts_sent);
            end
            if (beat_drop) begin
                beats_dropped <= sat_inc(beats_dropped);
            end
            // A dropped packet also counts its empty beats above
            if (packet_drop) begin
                pkts_dropped <= sat_inc(pkts_dropped);
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/keep_filter_fifo.sv */
// Packet keep filter core
// Store-and-forward packet FIFO that drops beats with an all-zero keep
// mask. One descriptor per packet carries its kept-beat count, from which
// the output last is rebuilt. Packets with no kept beat are dropped whole

`timescale 1ns/10ps
`default_nettype none

`include "keep_filter_consts.svh"

module keep_filter_fifo
    import keep_filter_pkg::*;
(
    input  logic   axis_out,
    input  logic   reset_w_bytes,
    input  logic   stg_tvalid,
    input  tdata_t stg_tdata,
    input  tkeep_t stg_tkeep,
    input  logic   stg_tlast,
    input  logic   stg_empty,
    output logic   stg_ready,
    output logic   out_tvalid,
    output tdata_t out_tdata,
    output tkeep_t out_tkeep,
    output logic   out_tlast,
    input  logic   out_tready,
    output logic   beat_drop,
    output logic   packet_drop
);

    localparam int DFIFO_W = `KF_KEEP_W + `KF_DATA_W;

    logic               stg_hs;
    logic               stg_end;
    logic               beat_kept;
    beat_cnt_t          wr_cnt;
    beat_cnt_t          pkt_cnt;
    logic               out_hs;
    beat_cnt_t          rd_cnt;
    beat_cnt_t          head_cnt;
    logic [DFIFO_W-1:0] head_beat;
    logic               data_full;
    logic               data_empty;
    logic               desc_full;
    logic               desc_empty;

    // Write side
    assign stg_hs    = stg_tvalid && stg_ready;
    assign stg_end   = stg_hs && stg_tlast;
    assign beat_kept = stg_hs && !stg_empty;

    // Count including the beat now transferring
    assign pkt_cnt = stg_empty ? wr_cnt : wr_cnt + 1'b1;

    // Room is needed in both FIFOs, whatever the beat turns out to be
    assign stg_ready = !data_full && !desc_full;

    assign beat_drop   = stg_hs && stg_empty;
    assign packet_drop = stg_end && (pkt_cnt == '0);

    always_ff @(posedge axis_out) begin
        if (reset_w_bytes) begin
            wr_cnt <= '0;
        end else if (stg_end) begin
            wr_cnt <= '0;
        end else if (beat_kept) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    sync_fifo #(
        .WIDTH (DFIFO_W),
        .DEPTH (`KF_DATA_DEPTH)
    ) data_fifo (
        .axis_out      (axis_out),
        .reset_w_bytes (reset_w_bytes),
        .wr_en         (beat_kept),
        .wr_data       ({stg_tkeep, stg_tdata}),
        .rd_en         (out_hs),
        .rd_data       (head_beat),
        .full          (data_full),
        .empty         (data_empty)
    );

    // Only packets with at least one kept beat get a descriptor
    sync_fifo #(
        .WIDTH (`KF_CNT_W),
        .DEPTH (`KF_DESC_DEPTH)
    ) desc_fifo (
        .axis_out      (axis_out),
        .reset_w_bytes (reset_w_bytes),
        .wr_en         (stg_end && (pkt_cnt != '0)),
        .wr_data       (pkt_cnt),
        .rd_en         (out_hs && out_tlast),
        .rd_data       (head_cnt),
        .full          (desc_full),
        .empty         (desc_empty)
    );

    // Packet released once its descriptor exists
    assign out_tvalid             = !desc_empty && !data_empty;
    assign {out_tkeep, out_tdata} = head_beat;
    assign out_hs                 = out_tvalid && out_tready;

    // Last beat of the head packet
    assign out_tlast = out_tvalid && (rd_cnt == beat_cnt_t'(head_cnt - 1'b1));

    always_ff @(posedge axis_out) begin
        if (reset_w_bytes) begin
            rd_cnt <= '0;
        end else if (out_hs && out_tlast) begin
            rd_cnt <= '0;
        end else if (out_hs) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/beat_status_stage.sv */
// Beat status stage
// One-beat register slice in front of the filter core. Each beat is
// captured together with its empty flag (keep mask all zero)

`timescale 1ns/10ps
`default_nettype none

module beat_status_stage
    import keep_filter_pkg::*;
(
    input  logic   axis_out,
    input  logic   reset_w_bytes,
    input  logic   in_tvalid,
    input  tdata_t in_tdata,
    input  tkeep_t in_tkeep,
    input  logic   in_tlast,
    output logic   in_tready,
    output logic   stg_tvalid,
    output tdata_t stg_tdata,
    output tkeep_t stg_tkeep,
    output logic   stg_tlast,
    output logic   stg_empty,
    input  logic   stg_ready
);

    logic rdy_en;
    logic in_hs;

    // Accept when the slot is free or its beat leaves this cycle
    assign in_tready = rdy_en && (!stg_tvalid || stg_ready);
    assign in_hs     = in_tvalid && in_tready;

    always_ff @(posedge axis_out) begin
        if (reset_w_bytes) begin
            rdy_en     <= 1'b0;
            stg_tvalid <= 1'b0;
        end else begin
            // Held off for the reset cycle itself
            rdy_en <= 1'b1;
            if (in_tready) begin
                stg_tvalid <= in_tvalid;
            end
        end
    end

    // Payload and flags, loaded only on a transfer
    always_ff @(posedge axis_out) begin
        if (in_hs) begin
            stg_tdata <= in_tdata;
            stg_tkeep <= in_tkeep;
            stg_tlast <= in_tlast;
            stg_empty <= (in_tkeep == '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/sync_fifo.sv */
// Synchronous FIFO
// Circular buffer with first-word fall-through read port,
// occupancy count and full / empty flags

`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             axis_out,
    input  logic             reset_w_bytes,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Overflow and underflow requests are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head word is always on the read port
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge axis_out) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge axis_out) begin
        if (reset_w_bytes) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/keep_filter_pkg.sv */
// Keep filter shared types
// Plain vector types for beat payload, keep mask, kept-beat count
// and statistics counter values

`default_nettype none

`include "keep_filter_consts.svh"

package keep_filter_pkg;

    // Stream payload of one beat
    typedef logic [`KF_DATA_W-1:0] tdata_t;

    // One bit per byte lane
    typedef logic [`KF_KEEP_W-1:0] tkeep_t;

    // Kept beats in one packet, also the descriptor FIFO word
    typedef logic [`KF_CNT_W-1:0]  beat_cnt_t;

    // Statistics counter value
    typedef logic [`KF_STAT_W-1:0] stat_t;

endpackage

`default_nettype wire

/* rtl/keep_filter_consts.svh */
// Keep filter widths and depths
// Stream geometry and FIFO sizes for the packet keep filter

`ifndef KEEP_FILTER_CONSTS_SVH
`define KEEP_FILTER_CONSTS_SVH

// Stream data width and byte keep width
`define KF_DATA_W      32
`define KF_KEEP_W      4

// Data FIFO depth bounds the kept beats per packet
`define KF_DATA_DEPTH  16

// Packets that can wait complete in the filter
`define KF_DESC_DEPTH  4

// Kept-beat count and statistics widths
`define KF_CNT_W       8
`define KF_STAT_W      16

`endif
